//--- src/tpu_pkg.sv
package tpu_pkg;

    // ######################################
    // widths and array geometry
    // ######################################

    // operand, accumulator and result word
    localparam int DATA_WIDTH = 32;
    // opcode field of a command
    localparam int CMD_WIDTH = 8;
    // rows = columns = lanes per buffer
    localparam int ARRAY_DIM = 4;
    // lane select width inside a buffer address
    localparam int LANE_BITS = $clog2(ARRAY_DIM);
    // skew on both edges plus the accumulate stage
    localparam int DRAIN_CYCLES = 2 * ARRAY_DIM;

    // ######################################
    // command opcodes
    // ######################################

    localparam logic [CMD_WIDTH-1:0] CMD_TRIGGER_CONV    = 8'd1;
    localparam logic [CMD_WIDTH-1:0] CMD_SW_WRITE_DATA   = 8'd9;
    localparam logic [CMD_WIDTH-1:0] CMD_SW_WRITE_WEIGHT = 8'd10;
    // param_1 selects the register, only 0 (K) is kept
    localparam logic [CMD_WIDTH-1:0] CMD_SET_KMN         = 8'd13;
    localparam logic [CMD_WIDTH-1:0] CMD_SW_READ_DATA    = 8'd14;

    // ######################################
    // shared structs
    // ######################################

    // one command as offered on the port
    typedef struct packed {
        logic                  valid;
        logic [CMD_WIDTH-1:0]  opcode;
        logic [DATA_WIDTH-1:0] param_1;
        logic [DATA_WIDTH-1:0] param_2;
    } tpu_cmd_t;

    // buffer location, low 16 bits of param_2
    typedef struct packed {
        logic [LANE_BITS-1:0] lane;
        logic [13:0]          addr;
    } buf_sel_t;

    // one software write into an operand buffer
    typedef struct packed {
        logic                  en;
        buf_sel_t              sel;
        logic [DATA_WIDTH-1:0] data;
    } lane_wr_t;

    // one slice per cycle or one result row
    // element 0 sits in the most significant word
    typedef logic [0:ARRAY_DIM-1][DATA_WIDTH-1:0] row_vec_t;

endpackage

//--- src/tpu_cmd_regs.sv
`timescale 1ns/1ps

module tpu_cmd_regs #(
    parameter int ADDR_BITS = 14
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  tpu_pkg::tpu_cmd_t    cmd_i,
    input  logic                 busy_i,
    output tpu_pkg::lane_wr_t    wr_data_o,
    output tpu_pkg::lane_wr_t    wr_weight_o,
    output logic [ADDR_BITS:0]   k_len_o,
    output logic                 start_o,
    output logic                 read_req_o,
    output logic [3:0]           read_idx_o
);

    // registered command, valid only if taken while idle
    tpu_pkg::tpu_cmd_t cmd_q;
    // write word shared by both buffers
    tpu_pkg::lane_wr_t wr_word;
    logic              set_k;

    // ######################################
    // command capture
    // ######################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmd_q.valid <= 1'b0;
        end else begin
            // offers during a run are dropped
            cmd_q.valid <= cmd_i.valid && !busy_i;
        end
        cmd_q.opcode  <= cmd_i.opcode;
        cmd_q.param_1 <= cmd_i.param_1;
        cmd_q.param_2 <= cmd_i.param_2;
    end

    // data in param_1, lane/address in param_2
    assign wr_word.en   = 1'b0;
    assign wr_word.sel  = tpu_pkg::buf_sel_t'(cmd_q.param_2[15:0]);
    assign wr_word.data = cmd_q.param_1;

    // ######################################
    // opcode decode
    // ######################################

    always_comb begin
        wr_data_o   = wr_word;
        wr_weight_o = wr_word;
        start_o     = 1'b0;
        read_req_o  = 1'b0;
        set_k       = 1'b0;
        if (cmd_q.valid) begin
            // unknown opcodes fall through
            case (cmd_q.opcode)
                tpu_pkg::CMD_SW_WRITE_DATA:   wr_data_o.en = 1'b1;
                tpu_pkg::CMD_SW_WRITE_WEIGHT: wr_weight_o.en = 1'b1;
                tpu_pkg::CMD_TRIGGER_CONV:    start_o = 1'b1;
                tpu_pkg::CMD_SW_READ_DATA:    read_req_o = 1'b1;
                tpu_pkg::CMD_SET_KMN:         set_k = 1'b1;
                default: ;
            endcase
        end
    end

    // word index 0..15 for the result read
    assign read_idx_o = cmd_q.param_1[3:0];

    // K register, selector 0 only
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            k_len_o <= (ADDR_BITS + 1)'(1);
        end else if (set_k && cmd_q.param_1 == '0) begin
            k_len_o <= cmd_q.param_2[ADDR_BITS:0];
        end
    end

endmodule

//--- src/tpu_seq.sv
`timescale 1ns/1ps

module tpu_seq #(
    parameter int ADDR_BITS = 14
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  logic                 read_req_i,
    input  logic [ADDR_BITS:0]   k_len_i,
    output logic                 rd_en_o,
    output logic [ADDR_BITS-1:0] rd_addr_o,
    output logic                 acc_clear_o,
    output logic                 store_o,
    output logic                 ret_valid_o,
    output logic                 busy_o
);

    // drain counter wide enough for DRAIN_CYCLES
    localparam int DRAIN_W = $clog2(tpu_pkg::DRAIN_CYCLES + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FEED,
        S_DRAIN,
        S_STORE,
        S_RD1,
        S_RD2,
        S_RD3,
        S_RET
    } state_t;

    state_t               state_q;
    state_t               state_d;
    // also the buffer read address
    logic [ADDR_BITS:0]   feed_cnt_q;
    logic [DRAIN_W-1:0]   drain_cnt_q;
    logic                 feed_last;
    logic                 drain_last;

    // last slice goes out this cycle
    assign feed_last  = (feed_cnt_q + 1'b1) >= k_len_i;
    // last in-flight product has landed in the far corner
    assign drain_last = drain_cnt_q == DRAIN_W'(tpu_pkg::DRAIN_CYCLES - 1);

    // ######################################
    // next state
    // ######################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    state_d = S_FEED;
                end else if (read_req_i) begin
                    state_d = S_RD1;
                end
            end
            S_FEED: begin
                if (feed_last) begin
                    state_d = S_DRAIN;
                end
            end
            S_DRAIN: begin
                if (drain_last) begin
                    state_d = S_STORE;
                end
            end
            S_STORE: state_d = S_IDLE;
            // word is registered in the result buffer meanwhile
            S_RD1:   state_d = S_RD2;
            S_RD2:   state_d = S_RD3;
            S_RD3:   state_d = S_RET;
            S_RET:   state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    // ######################################
    // state and counters
    // ######################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= S_IDLE;
            feed_cnt_q  <= '0;
            drain_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            // both counters sit at zero outside their state
            feed_cnt_q  <= (state_q == S_FEED) ? feed_cnt_q + 1'b1 : '0;
            drain_cnt_q <= (state_q == S_DRAIN) ? drain_cnt_q + 1'b1 : '0;
        end
    end

    // shared address for data and weight buffers
    assign rd_en_o   = state_q == S_FEED;
    assign rd_addr_o = feed_cnt_q[ADDR_BITS-1:0];

    // accumulators cleared on the edge that enters feed
    assign acc_clear_o = (state_q == S_IDLE) && start_i;
    assign store_o     = state_q == S_STORE;
    assign ret_valid_o = state_q == S_RET;
    assign busy_o      = state_q != S_IDLE;

endmodule

//--- src/operand_buffer.sv
`timescale 1ns/1ps

module operand_buffer #(
    parameter int ADDR_BITS = 14
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  tpu_pkg::lane_wr_t    wr_i,
    input  logic                 rd_en_i,
    input  logic [ADDR_BITS-1:0] rd_addr_i,
    output tpu_pkg::row_vec_t    rd_data_o
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    // one memory per lane
    logic [tpu_pkg::DATA_WIDTH-1:0] mem [tpu_pkg::ARRAY_DIM][DEPTH];

    // ######################################
    // software write port
    // ######################################

    // only the named lane takes the word
    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem[wr_i.sel.lane][wr_i.sel.addr[ADDR_BITS-1:0]] <= wr_i.data;
        end
    end

    // ######################################
    // array read port
    // ######################################

    // all lanes at one address
    // zeros outside the feed window keep the array quiet
    always_ff @(posedge clk_i) begin
        for (int l = 0; l < tpu_pkg::ARRAY_DIM; l++) begin
            if (rst_i || !rd_en_i) begin
                rd_data_o[l] <= '0;
            end else begin
                rd_data_o[l] <= mem[l][rd_addr_i];
            end
        end
    end

endmodule

//--- src/systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic                                         clear_i,
    input  tpu_pkg::row_vec_t                            data_i,
    input  tpu_pkg::row_vec_t                            weight_i,
    output tpu_pkg::row_vec_t [0:tpu_pkg::ARRAY_DIM-1]   acc_o
);

    localparam int N = tpu_pkg::ARRAY_DIM;
    localparam int W = tpu_pkg::DATA_WIDTH;

    // operand seen by PE (i,j)
    // a moves right along a row, b moves down a column
    logic [W-1:0] a_w [N][N];
    logic [W-1:0] b_w [N][N];

    // ######################################
    // input skew
    // ######################################

    // row k and column k both delayed by k cycles
    for (genvar k = 0; k < N; k++) begin : g_skew
        if (k == 0) begin : g_direct
            assign a_w[0][0] = data_i[0];
            assign b_w[0][0] = weight_i[0];
        end else begin : g_delay
            logic [W-1:0] a_sr [1:k];
            logic [W-1:0] b_sr [1:k];

            always_ff @(posedge clk_i) begin
                a_sr[1] <= data_i[k];
                b_sr[1] <= weight_i[k];
                for (int s = 2; s <= k; s++) begin
                    a_sr[s] <= a_sr[s-1];
                    b_sr[s] <= b_sr[s-1];
                end
            end

            // row k enters at column 0, column k at row 0
            assign a_w[k][0] = a_sr[k];
            assign b_w[0][k] = b_sr[k];
        end
    end

    // ######################################
    // PE grid
    // ######################################

    // pair k meets at PE (i,j) after i+j cycles
    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            logic [W-1:0] acc_q;

            // product and sum wrap at W bits
            always_ff @(posedge clk_i) begin
                if (rst_i || clear_i) begin
                    acc_q <= '0;
                end else begin
                    acc_q <= acc_q + a_w[i][j] * b_w[i][j];
                end
            end

            assign acc_o[i][j] = acc_q;

            // pass data to the right neighbour
            if (j < N - 1) begin : g_pass_a
                logic [W-1:0] a_q;

                always_ff @(posedge clk_i) begin
                    a_q <= a_w[i][j];
                end

                assign a_w[i][j+1] = a_q;
            end

            // pass weight to the PE below
            if (i < N - 1) begin : g_pass_b
                logic [W-1:0] b_q;

                always_ff @(posedge clk_i) begin
                    b_q <= b_w[i][j];
                end

                assign b_w[i+1][j] = b_q;
            end
        end
    end

endmodule

//--- src/result_buffer.sv
`timescale 1ns/1ps

module result_buffer (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic                                         store_i,
    input  tpu_pkg::row_vec_t [0:tpu_pkg::ARRAY_DIM-1]   rows_i,
    input  logic                                         read_req_i,
    input  logic [3:0]                                   read_idx_i,
    output logic [tpu_pkg::DATA_WIDTH-1:0]               word_o
);

    // result rows of the last run
    tpu_pkg::row_vec_t [0:tpu_pkg::ARRAY_DIM-1] rows_q;

    // ######################################
    // capture after drain
    // ######################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rows_q <= '0;
        end else if (store_i) begin
            rows_q <= rows_i;
        end
    end

    // ######################################
    // software read
    // ######################################

    // idx/4 picks the row, idx%4 the column
    // column 0 is the most significant word
    always_ff @(posedge clk_i) begin
        if (read_req_i) begin
            word_o <= rows_q[read_idx_i[3:2]][read_idx_i[1:0]];
        end
    end

endmodule

//--- src/tpu_top.sv
`timescale 1ns/1ps

module tpu_top #(
    parameter int ADDR_BITS = 14
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              tpu_cmd_valid_i,
    input  logic [tpu_pkg::CMD_WIDTH-1:0]     tpu_cmd_i,
    input  logic [tpu_pkg::DATA_WIDTH-1:0]    tpu_param_1_i,
    input  logic [tpu_pkg::DATA_WIDTH-1:0]    tpu_param_2_i,
    output logic                              ret_valid_o,
    output logic [tpu_pkg::DATA_WIDTH-1:0]    ret_data_o,
    output logic                              tpu_busy_o
);

    tpu_pkg::tpu_cmd_t                          cmd;
    tpu_pkg::lane_wr_t                          wr_data;
    tpu_pkg::lane_wr_t                          wr_weight;
    logic [ADDR_BITS:0]                         k_len;
    logic                                       start;
    logic                                       read_req;
    logic [3:0]                                 read_idx;
    logic                                       rd_en;
    logic [ADDR_BITS-1:0]                       rd_addr;
    logic                                       acc_clear;
    logic                                       store;
    tpu_pkg::row_vec_t                          data_row;
    tpu_pkg::row_vec_t                          weight_row;
    tpu_pkg::row_vec_t [0:tpu_pkg::ARRAY_DIM-1] acc_rows;
    logic [tpu_pkg::DATA_WIDTH-1:0]             read_word;

    // command port bundled for the register block
    assign cmd = '{
        valid:   tpu_cmd_valid_i,
        opcode:  tpu_cmd_i,
        param_1: tpu_param_1_i,
        param_2: tpu_param_2_i
    };

    // ######################################
    // control
    // ######################################

    tpu_cmd_regs #(.ADDR_BITS(ADDR_BITS)) u_cmd_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_i       (cmd),
        .busy_i      (tpu_busy_o),
        .wr_data_o   (wr_data),
        .wr_weight_o (wr_weight),
        .k_len_o     (k_len),
        .start_o     (start),
        .read_req_o  (read_req),
        .read_idx_o  (read_idx)
    );

    tpu_seq #(.ADDR_BITS(ADDR_BITS)) u_seq (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start),
        .read_req_i  (read_req),
        .k_len_i     (k_len),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .acc_clear_o (acc_clear),
        .store_o     (store),
        .ret_valid_o (ret_valid_o),
        .busy_o      (tpu_busy_o)
    );

    // ######################################
    // datapath
    // ######################################

    // lane i of A feeds row i
    operand_buffer #(.ADDR_BITS(ADDR_BITS)) u_data_buf (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_i      (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (data_row)
    );

    // lane j of B feeds column j
    operand_buffer #(.ADDR_BITS(ADDR_BITS)) u_weight_buf (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_i      (wr_weight),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (weight_row)
    );

    systolic_array u_array (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .clear_i  (acc_clear),
        .data_i   (data_row),
        .weight_i (weight_row),
        .acc_o    (acc_rows)
    );

    result_buffer u_result (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .store_i    (store),
        .rows_i     (acc_rows),
        .read_req_i (read_req),
        .read_idx_i (read_idx),
        .word_o     (read_word)
    );

    // data bus is zero outside the return cycle
    assign ret_data_o = read_word & {tpu_pkg::DATA_WIDTH{ret_valid_o}};

endmodule

//--- testbench/tb_tpu_top.sv
`timescale 1ns/1ps

module tb_tpu_top;

    localparam int ADDR_BITS = 14;
    localparam int DIM = tpu_pkg::ARRAY_DIM;
    localparam int MAX_K = 64;
    // rough cycle costs, used only by the watchdog
    localparam int CMD_CYCLES = 2;
    localparam int READ_CYCLES = 8;

    logic                           clk_i;
    logic                           rst_i;
    logic                           tpu_cmd_valid_i;
    logic [tpu_pkg::CMD_WIDTH-1:0]  tpu_cmd_i;
    logic [31:0]                    tpu_param_1_i;
    logic [31:0]                    tpu_param_2_i;
    logic                           ret_valid_o;
    logic [31:0]                    ret_data_o;
    logic                           tpu_busy_o;

    // copies of what the DUT buffers should hold
    logic [31:0] a_mat [DIM][MAX_K];
    logic [31:0] b_mat [MAX_K][DIM];
    // expected result of the last finished run
    logic [31:0] exp_c [DIM][DIM];
    int          k_held;

    // pending reads, oldest first
    logic [31:0] exp_q [$];
    int          idx_q [$];
    string       test_name;
    int          value_errors = 0;
    int          protocol_errors = 0;

    tpu_top #(.ADDR_BITS(ADDR_BITS)) u_dut (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .tpu_cmd_valid_i (tpu_cmd_valid_i),
        .tpu_cmd_i       (tpu_cmd_i),
        .tpu_param_1_i   (tpu_param_1_i),
        .tpu_param_2_i   (tpu_param_2_i),
        .ret_valid_o     (ret_valid_o),
        .ret_data_o      (ret_data_o),
        .tpu_busy_o      (tpu_busy_o)
    );

    // 20 ns period
    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ######################################
    // reference model
    // ######################################

    // C[i][j] over the first k terms, wraps at 32 bits
    function automatic logic [31:0] matmul_elem(input int i, input int j, input int k);
        logic [31:0] sum;
        sum = '0;
        for (int kk = 0; kk < k; kk++) begin
            sum = sum + a_mat[i][kk] * b_mat[kk][j];
        end
        return sum;
    endfunction

    // lane in bits 15:14, address below
    function automatic logic [31:0] buf_loc(input int lane, input int addr);
        return {16'd0, 2'(lane), 14'(addr)};
    endfunction

    // watchdog budget pieces
    function automatic int load_cycles(input int k);
        return (2 * DIM * k + 1) * CMD_CYCLES;
    endfunction

    // trigger, busy window and a full readback
    function automatic int run_cycles(input int k);
        return k + tpu_pkg::DRAIN_CYCLES + 8 + DIM * DIM * READ_CYCLES;
    endfunction

    // ######################################
    // command tasks
    // ######################################

    // valid for one cycle, starting on a falling edge
    task automatic send_cmd(input logic [7:0] op, input logic [31:0] p1, input logic [31:0] p2);
        @(negedge clk_i);
        tpu_cmd_valid_i = 1'b1;
        tpu_cmd_i       = op;
        tpu_param_1_i   = p1;
        tpu_param_2_i   = p2;
        @(negedge clk_i);
        tpu_cmd_valid_i = 1'b0;
    endtask

    // lane r of data is row r of A, lane r of weights is column r of B
    task automatic load_operands(input int k, input bit near_max);
        for (int r = 0; r < DIM; r++) begin
            for (int kk = 0; kk < k; kk++) begin
                a_mat[r][kk] = near_max ? (32'hFFFF_FFFF - ($urandom() & 32'hFF)) : $urandom();
                b_mat[kk][r] = near_max ? (32'hFFFF_FFFF - ($urandom() & 32'hFF)) : $urandom();
                send_cmd(tpu_pkg::CMD_SW_WRITE_DATA, a_mat[r][kk], buf_loc(r, kk));
                send_cmd(tpu_pkg::CMD_SW_WRITE_WEIGHT, b_mat[kk][r], buf_loc(r, kk));
            end
        end
        // selector 0 is K
        send_cmd(tpu_pkg::CMD_SET_KMN, 32'd0, 32'(k));
        k_held = k;
    endtask

    task automatic start_run();
        send_cmd(tpu_pkg::CMD_TRIGGER_CONV, 32'd0, 32'd0);
        // busy rises on the edge after acceptance
        @(negedge clk_i);
        if (tpu_busy_o !== 1'b1) begin
            $display("ERROR %s: busy did not rise after the trigger", test_name);
            protocol_errors++;
        end
    endtask

    // busy fall ends the run, then expectations follow the copies
    task automatic finish_run();
        while (tpu_busy_o !== 1'b0) begin
            @(negedge clk_i);
        end
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                exp_c[i][j] = matmul_elem(i, j, k_held);
            end
        end
    endtask

    // all of these land while the array is running
    task automatic offer_while_busy();
        send_cmd(tpu_pkg::CMD_SW_WRITE_DATA, 32'hDEAD_BEEF, buf_loc(0, 0));
        send_cmd(tpu_pkg::CMD_SW_WRITE_WEIGHT, 32'h1234_5678, buf_loc(3, 1));
        send_cmd(tpu_pkg::CMD_SET_KMN, 32'd0, 32'd2);
        if (tpu_busy_o !== 1'b1) begin
            $display("ERROR %s: run ended before the offered commands", test_name);
            protocol_errors++;
        end
    endtask

    // word idx is row idx/4, column idx%4
    task automatic read_result(input int idx);
        logic exp_busy;
        logic exp_valid;
        exp_q.push_back(exp_c[idx / DIM][idx % DIM]);
        idx_q.push_back(idx);
        send_cmd(tpu_pkg::CMD_SW_READ_DATA, 32'(idx), 32'd0);
        // sampled after edges E+1 .. E+5
        for (int c = 1; c <= 5; c++) begin
            @(negedge clk_i);
            exp_busy  = c <= 4;
            exp_valid = c == 4;
            if (tpu_busy_o !== exp_busy) begin
                $display("ERROR %s: busy wrong %0d cycles into read of word %0d",
                         test_name, c, idx);
                protocol_errors++;
            end
            if (ret_valid_o !== exp_valid) begin
                $display("ERROR %s: ret_valid wrong %0d cycles into read of word %0d",
                         test_name, c, idx);
                protocol_errors++;
            end
        end
    endtask

    task automatic read_all();
        for (int idx = 0; idx < DIM * DIM; idx++) begin
            read_result(idx);
        end
    endtask

    // ######################################
    // return checker
    // ######################################

    always @(negedge clk_i) begin : compare_ret
        logic [31:0] want;
        int          idx;
        if (rst_i === 1'b0) begin
            if (ret_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR %s: ret_valid with no read pending", test_name);
                    protocol_errors++;
                end else begin
                    want = exp_q.pop_front();
                    idx  = idx_q.pop_front();
                    if (ret_data_o !== want) begin
                        $display("FAIL %s word %0d: expected %08h, actual %08h",
                                 test_name, idx, want, ret_data_o);
                        value_errors++;
                    end
                end
            end else if (ret_data_o !== '0) begin
                // bus must stay quiet outside the return cycle
                $display("ERROR %s: ret_data not zero while ret_valid is low", test_name);
                protocol_errors++;
            end
        end
    end

    // ######################################
    // watchdog
    // ######################################

    initial begin : watchdog
        int budget;
        budget = 12 + DIM * DIM * READ_CYCLES
               + load_cycles(4) + run_cycles(4)
               + load_cycles(1) + run_cycles(1)
               + load_cycles(37) + run_cycles(37)
               + 3 * CMD_CYCLES + 2 * run_cycles(37)
               + load_cycles(4) + 2 * run_cycles(4);
        repeat (2 * budget) @(posedge clk_i);
        $display("ERROR: timeout, the run did not finish within %0d cycles", 2 * budget);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ######################################
    // test sequence
    // ######################################

    initial begin : main
        rst_i           = 1'b1;
        tpu_cmd_valid_i = 1'b0;
        tpu_cmd_i       = '0;
        tpu_param_1_i   = '0;
        tpu_param_2_i   = '0;
        k_held          = 1;
        void'($urandom(87));
        test_name = "reset";
        // ten cycles of reset, outputs checked each cycle
        for (int c = 0; c < 10; c++) begin
            @(posedge clk_i);
            @(negedge clk_i);
            if (tpu_busy_o !== 1'b0 || ret_valid_o !== 1'b0) begin
                $display("ERROR reset: busy or ret_valid high during reset");
                protocol_errors++;
            end
        end
        rst_i = 1'b0;
        // result rows come out of reset as zero
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                exp_c[i][j] = '0;
            end
        end
        test_name = "read_before_run";
        read_all();

        test_name = "k4_random";
        load_operands(4, 1'b0);
        start_run();
        finish_run();
        read_all();

        // also shows accumulators clear between runs
        test_name = "k1_near_max";
        load_operands(1, 1'b1);
        start_run();
        finish_run();
        read_all();

        test_name = "k37_near_max";
        load_operands(37, 1'b1);
        start_run();
        finish_run();
        read_all();

        // copies untouched, so the same product twice
        test_name = "busy_ignores_cmds";
        start_run();
        offer_while_busy();
        finish_run();
        read_all();
        start_run();
        finish_run();
        read_all();

        // second trigger with no SET_KMN in between
        test_name = "held_k_rerun";
        load_operands(4, 1'b0);
        start_run();
        finish_run();
        read_all();
        start_run();
        finish_run();
        read_all();

        if (exp_q.size() != 0) begin
            $display("ERROR: %0d reads never returned data", exp_q.size());
            protocol_errors++;
        end
        $display("summary: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tpu_top.f
src/tpu_pkg.sv
src/tpu_cmd_regs.sv
src/tpu_seq.sv
src/operand_buffer.sv
src/systolic_array.sv
src/result_buffer.sv
src/tpu_top.sv
testbench/tb_tpu_top.sv

//--- run.sh
#!/bin/sh
# build and run the tpu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f tpu_top.f \
    --top-module tb_tpu_top \
    -Mdir obj_dir \
    -o sim_tb_tpu_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb_tpu_top)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
